/* hdl/snn_config.svh */
`ifndef SNN_CONFIG_SVH
`define SNN_CONFIG_SVH

// Input channels per spike row
`define SNN_IN_DIM       8
// Neurons per projection unit
`define SNN_OUT_DIM      4
`define SNN_TIME_STEPS   4

// Signed weight and accumulator widths
`define SNN_W_WIDTH      8
`define SNN_PSUM_WIDTH   20
`define SNN_LIF_THRESH   16

// Q, K and V units share the weight memory
`define SNN_N_MASTERS    3
`define SNN_WMEM_DEPTH   96
`define SNN_ADDR_WIDTH   7
`define SNN_LEN_WIDTH    4

`endif

/* hdl/snn_pkg.sv */
`include "snn_config.svh"

package snn_pkg;

    // Burst read request from a master
    typedef struct packed {
        logic                         req;
        logic [`SNN_ADDR_WIDTH-1:0]   addr;
        logic [`SNN_LEN_WIDTH-1:0]    len;
    } burst_req_t;

    // Burst read response, finish rides with the last word
    typedef struct packed {
        logic [`SNN_W_WIDTH-1:0]      data;
        logic                         valid;
        logic                         finish;
    } burst_rsp_t;

    // Weight load port
    typedef struct packed {
        logic                         we;
        logic [`SNN_ADDR_WIDTH-1:0]   addr;
        logic [`SNN_W_WIDTH-1:0]      data;
    } wload_t;

    // Input spikes, indexed [t][i]
    typedef logic [`SNN_TIME_STEPS-1:0][`SNN_IN_DIM-1:0] spike_row_t;

    // Output spikes, indexed [n][t]
    typedef logic [`SNN_OUT_DIM-1:0][`SNN_TIME_STEPS-1:0] spike_out_t;

    typedef logic signed [`SNN_PSUM_WIDTH-1:0] psum_t;

    typedef enum logic [1:0] {U_IDLE, U_FETCH, U_FIRE, U_DONE} unit_state_e;

    typedef enum logic [1:0] {J_IDLE, J_RUN, J_ACK} job_state_e;

endpackage

/* hdl/weight_mem.sv */
`timescale 1ns/10ps
`include "snn_config.svh"

module weight_mem (
    input  logic                s_clk,
    input  logic                rst_n,
    input  snn_pkg::wload_t     wload,
    input  snn_pkg::burst_req_t mem_req,
    output snn_pkg::burst_rsp_t mem_rsp
);

    logic [`SNN_W_WIDTH-1:0]    mem [`SNN_WMEM_DEPTH];

    logic                       busy;
    logic [`SNN_ADDR_WIDTH-1:0] rd_ptr;
    logic [`SNN_LEN_WIDTH-1:0]  remaining;

    // Load port, words past the end are dropped
    always_ff @(posedge s_clk) begin
        if (wload.we && (int'(wload.addr) < `SNN_WMEM_DEPTH)) begin
            mem[wload.addr] <= wload.data;
        end
    end

    always_ff @(posedge s_clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            rd_ptr    <= '0;
            remaining <= '0;
        end else if (!busy) begin
            if (mem_req.req && (mem_req.len != '0)) begin
                busy      <= 1'b1;
                rd_ptr    <= mem_req.addr;
                remaining <= mem_req.len;
            end
        end else begin
            rd_ptr    <= rd_ptr + 1'b1;
            remaining <= remaining - 1'b1;
            if (remaining == `SNN_LEN_WIDTH'(1)) begin
                busy <= 1'b0;
            end
        end
    end

    // One word per cycle while the burst runs
    always_comb begin
        mem_rsp        = '0;
        mem_rsp.valid  = busy;
        mem_rsp.finish = busy && (remaining == `SNN_LEN_WIDTH'(1));
        if (busy) begin
            mem_rsp.data = mem[rd_ptr];
        end
    end

endmodule

/* hdl/burst_rr_arbiter.sv */
`timescale 1ns/10ps
`include "snn_config.svh"

module burst_rr_arbiter (
    input  logic                s_clk,
    input  logic                rst_n,
    input  snn_pkg::burst_req_t m_req [`SNN_N_MASTERS],
    output snn_pkg::burst_rsp_t m_rsp [`SNN_N_MASTERS],
    output snn_pkg::burst_req_t mem_req,
    input  snn_pkg::burst_rsp_t mem_rsp
);

    localparam int N  = `SNN_N_MASTERS;
    localparam int IW = $clog2(N);

    logic          busy;
    logic [IW-1:0] grant;
    logic [IW-1:0] last;
    logic [IW-1:0] pick;
    logic          found;

    // Search starts after the last master served, last itself comes least
    always_comb begin
        int idx;
        pick  = last;
        found = 1'b0;
        idx   = 0;
        for (int k = N; k >= 1; k--) begin
            idx = (int'(last) + k) % N;
            if (m_req[idx].req) begin
                pick  = IW'(idx);
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge s_clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            grant <= '0;
            last  <= IW'(N - 1);
        end else if (!busy) begin
            if (found) begin
                busy  <= 1'b1;
                grant <= pick;
                last  <= pick;
            end
        end else if (mem_rsp.finish) begin
            // Idle again on the cycle after the last word
            busy <= 1'b0;
        end
    end

    always_comb begin
        mem_req = '0;
        if (busy) begin
            mem_req = m_req[grant];
        end
    end

    // Only the granted master sees the response
    always_comb begin
        for (int i = 0; i < N; i++) begin
            if (busy && (grant == IW'(i))) begin
                m_rsp[i] = mem_rsp;
            end else begin
                m_rsp[i] = '0;
            end
        end
    end

endmodule

/* hdl/linear_lif_unit.sv */
`timescale 1ns/10ps
`include "snn_config.svh"

module linear_lif_unit #(
    parameter int UNIT_BASE = 0
) (
    input  logic                s_clk,
    input  logic                rst_n,
    input  logic                run,
    input  snn_pkg::spike_row_t spike_in,
    output snn_pkg::burst_req_t bus_req,
    input  snn_pkg::burst_rsp_t bus_rsp,
    output snn_pkg::spike_out_t spikes,
    output logic                done
);

    localparam int T  = `SNN_TIME_STEPS;
    localparam int NI = `SNN_IN_DIM;
    localparam int NO = `SNN_OUT_DIM;
    localparam int IW = $clog2(NI);
    localparam int NW = $clog2(NO);

    snn_pkg::unit_state_e state;
    snn_pkg::spike_row_t  spike_q;
    logic [NW-1:0]        n_cnt;
    logic [IW-1:0]        i_cnt;
    logic                 req_q;
    logic                 last_neuron;
    logic                 clr_acc;
    logic                 acc_en;
    snn_pkg::psum_t       w_ext;
    snn_pkg::psum_t       acc [T];
    logic [T-1:0]         fire_bits;

    assign last_neuron = (n_cnt == NW'(NO - 1));
    assign w_ext       = snn_pkg::psum_t'($signed(bus_rsp.data));
    assign acc_en      = (state == snn_pkg::U_FETCH) && bus_rsp.valid;
    assign clr_acc     = ((state == snn_pkg::U_IDLE) && run) ||
                         ((state == snn_pkg::U_FIRE) && !last_neuron);
    assign done        = (state == snn_pkg::U_DONE);

    // Row of weights for neuron n
    always_comb begin
        bus_req      = '0;
        bus_req.req  = req_q;
        bus_req.addr = `SNN_ADDR_WIDTH'(UNIT_BASE + int'(n_cnt) * NI);
        bus_req.len  = `SNN_LEN_WIDTH'(NI);
    end

    always_ff @(posedge s_clk) begin
        if (!rst_n) begin
            state  <= snn_pkg::U_IDLE;
            n_cnt  <= '0;
            i_cnt  <= '0;
            req_q  <= 1'b0;
            spikes <= '0;
        end else begin
            case (state)
                snn_pkg::U_IDLE: begin
                    if (run) begin
                        n_cnt <= '0;
                        i_cnt <= '0;
                        req_q <= 1'b1;
                        state <= snn_pkg::U_FETCH;
                    end
                end
                snn_pkg::U_FETCH: begin
                    if (bus_rsp.valid) begin
                        i_cnt <= i_cnt + 1'b1;
                    end
                    // Request drops the cycle after finish
                    if (bus_rsp.finish) begin
                        req_q <= 1'b0;
                        i_cnt <= '0;
                        state <= snn_pkg::U_FIRE;
                    end
                end
                snn_pkg::U_FIRE: begin
                    spikes[n_cnt] <= fire_bits;
                    if (last_neuron) begin
                        state <= snn_pkg::U_DONE;
                    end else begin
                        n_cnt <= n_cnt + 1'b1;
                        req_q <= 1'b1;
                        state <= snn_pkg::U_FETCH;
                    end
                end
                snn_pkg::U_DONE: begin
                    state <= snn_pkg::U_IDLE;
                end
                default: begin
                    state <= snn_pkg::U_IDLE;
                end
            endcase
        end
    end

    // Spike row is captured once per job
    always_ff @(posedge s_clk) begin
        if ((state == snn_pkg::U_IDLE) && run) begin
            spike_q <= spike_in;
        end
    end

    // One accumulator per time step, weight i counts where spike [t][i] is set
    always_ff @(posedge s_clk) begin
        if (clr_acc) begin
            for (int t = 0; t < T; t++) begin
                acc[t] <= '0;
            end
        end else if (acc_en) begin
            for (int t = 0; t < T; t++) begin
                if (spike_q[t][i_cnt]) begin
                    acc[t] <= acc[t] + w_ext;
                end
            end
        end
    end

    // LIF over the time steps of one neuron
    always_comb begin
        snn_pkg::psum_t v;
        v = '0;
        for (int t = 0; t < T; t++) begin
            v = v + acc[t];
            if (v >= snn_pkg::psum_t'(`SNN_LIF_THRESH)) begin
                fire_bits[t] = 1'b1;
                v            = '0;
            end else begin
                // Membrane keeps negative values too
                fire_bits[t] = 1'b0;
            end
        end
    end

endmodule

/* hdl/qkv_spike_top.sv */
`timescale 1ns/10ps
`include "snn_config.svh"

module qkv_spike_top (
    input  logic                s_clk,
    input  logic                rst_n,
    input  logic                job_req,
    output logic                job_ack,
    input  snn_pkg::spike_row_t spike_in,
    input  snn_pkg::wload_t     wload,
    output snn_pkg::spike_out_t q_spikes,
    output snn_pkg::spike_out_t k_spikes,
    output snn_pkg::spike_out_t v_spikes
);

    localparam int N          = `SNN_N_MASTERS;
    localparam int UNIT_WORDS = `SNN_IN_DIM * `SNN_OUT_DIM;

    snn_pkg::job_state_e state;
    logic                run;
    logic [N-1:0]        unit_done;
    logic [N-1:0]        done_mask;

    snn_pkg::burst_req_t m_req [N];
    snn_pkg::burst_rsp_t m_rsp [N];
    snn_pkg::burst_req_t mem_req;
    snn_pkg::burst_rsp_t mem_rsp;
    snn_pkg::spike_out_t q_raw;
    snn_pkg::spike_out_t k_raw;
    snn_pkg::spike_out_t v_raw;

    assign job_ack = (state == snn_pkg::J_ACK);

    // Four-phase job handshake
    always_ff @(posedge s_clk) begin
        if (!rst_n) begin
            state     <= snn_pkg::J_IDLE;
            run       <= 1'b0;
            done_mask <= '0;
            q_spikes  <= '0;
            k_spikes  <= '0;
            v_spikes  <= '0;
        end else begin
            run <= 1'b0;
            case (state)
                snn_pkg::J_IDLE: begin
                    if (job_req) begin
                        run       <= 1'b1;
                        done_mask <= '0;
                        state     <= snn_pkg::J_RUN;
                    end
                end
                snn_pkg::J_RUN: begin
                    done_mask <= done_mask | unit_done;
                    if (&done_mask) begin
                        q_spikes <= q_raw;
                        k_spikes <= k_raw;
                        v_spikes <= v_raw;
                        state    <= snn_pkg::J_ACK;
                    end
                end
                snn_pkg::J_ACK: begin
                    if (!job_req) begin
                        state <= snn_pkg::J_IDLE;
                    end
                end
                default: begin
                    state <= snn_pkg::J_IDLE;
                end
            endcase
        end
    end

    weight_mem u_wmem (
        .s_clk   (s_clk),
        .rst_n   (rst_n),
        .wload   (wload),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    burst_rr_arbiter u_arb (
        .s_clk   (s_clk),
        .rst_n   (rst_n),
        .m_req   (m_req),
        .m_rsp   (m_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    linear_lif_unit #(.UNIT_BASE(0)) u_q (
        .s_clk    (s_clk),
        .rst_n    (rst_n),
        .run      (run),
        .spike_in (spike_in),
        .bus_req  (m_req[0]),
        .bus_rsp  (m_rsp[0]),
        .spikes   (q_raw),
        .done     (unit_done[0])
    );

    linear_lif_unit #(.UNIT_BASE(UNIT_WORDS)) u_k (
        .s_clk    (s_clk),
        .rst_n    (rst_n),
        .run      (run),
        .spike_in (spike_in),
        .bus_req  (m_req[1]),
        .bus_rsp  (m_rsp[1]),
        .spikes   (k_raw),
        .done     (unit_done[1])
    );

    linear_lif_unit #(.UNIT_BASE(2 * UNIT_WORDS)) u_v (
        .s_clk    (s_clk),
        .rst_n    (rst_n),
        .run      (run),
        .spike_in (spike_in),
        .bus_req  (m_req[2]),
        .bus_rsp  (m_rsp[2]),
        .spikes   (v_raw),
        .done     (unit_done[2])
    );

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int HALF_PERIOD = 5,
    parameter int RESET_CYCLES = 2
) (
    output logic s_clk,
    output logic rst_n
);

    initial begin
        s_clk = 1'b0;
        forever #HALF_PERIOD s_clk = ~s_clk;
    end

    // Release a little after the edge, like the other inputs
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge s_clk);
        #1 rst_n = 1'b1;
    end

endmodule

/* tests/qkv_spike_tb.sv */
`timescale 1ns/10ps
`include "snn_config.svh"

module qkv_spike_tb;

    localparam int NUM_ENTRIES = 8;
    localparam int CYCLE_LIMIT = NUM_ENTRIES * 400 + 200;
    localparam int UNIT_WORDS  = `SNN_IN_DIM * `SNN_OUT_DIM;
    localparam int HOLD_CYCLES = 5;

    // Weight set selectors
    localparam logic [2:0] W_RAMP = 3'd0;
    localparam logic [2:0] W_POS  = 3'd1;
    localparam logic [2:0] W_NEG  = 3'd2;
    localparam logic [2:0] W_RAND = 3'd3;
    localparam logic [2:0] W_EDGE = 3'd4;

    typedef struct packed {
        snn_pkg::spike_row_t row;
        logic [2:0]          sel;
        logic                has_exp;
        snn_pkg::spike_out_t exp_q;
    } entry_t;

    logic                s_clk;
    logic                rst_n;
    logic                job_req;
    logic                job_ack;
    snn_pkg::spike_row_t spike_in;
    snn_pkg::wload_t     wload;
    snn_pkg::spike_out_t q_spikes;
    snn_pkg::spike_out_t k_spikes;
    snn_pkg::spike_out_t v_spikes;

    entry_t                         tests [NUM_ENTRIES];
    logic signed [`SNN_W_WIDTH-1:0] wmodel [`SNN_WMEM_DEPTH];
    logic [31:0]                    lcg_state;
    snn_pkg::spike_out_t            exp_q;
    snn_pkg::spike_out_t            exp_k;
    snn_pkg::spike_out_t            exp_v;
    int                             errors;
    int                             checks;
    int                             cycles = 0;

    tb_clk_gen u_clk (
        .s_clk (s_clk),
        .rst_n (rst_n)
    );

    qkv_spike_top u_dut (
        .s_clk    (s_clk),
        .rst_n    (rst_n),
        .job_req  (job_req),
        .job_ack  (job_ack),
        .spike_in (spike_in),
        .wload    (wload),
        .q_spikes (q_spikes),
        .k_spikes (k_spikes),
        .v_spikes (v_spikes)
    );

    always @(posedge s_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Fixed weight patterns over the whole address
    function automatic logic signed [`SNN_W_WIDTH-1:0] pattern_weight(
        input logic [2:0] sel,
        input int a
    );
        int u;
        int n;
        int i;
        int v;
        u = a / UNIT_WORDS;
        n = (a % UNIT_WORDS) / `SNN_IN_DIM;
        i = a % `SNN_IN_DIM;
        case (sel)
            W_RAMP: v = a - 48;
            W_POS:  v = 1 + (a % 7);
            W_NEG:  v = -(1 + (a % 5));
            W_EDGE: v = (i == n) ? `SNN_LIF_THRESH : -(1 + u);
            default: v = 0;
        endcase
        return `SNN_W_WIDTH'(v);
    endfunction

    // Expected spikes of one unit from the accumulate and LIF rules
    function automatic snn_pkg::spike_out_t predict_spikes(
        input snn_pkg::spike_row_t row,
        input int base
    );
        snn_pkg::spike_out_t res;
        int psum;
        int membrane;
        res = '0;
        for (int n = 0; n < `SNN_OUT_DIM; n++) begin
            membrane = 0;
            for (int t = 0; t < `SNN_TIME_STEPS; t++) begin
                psum = 0;
                for (int i = 0; i < `SNN_IN_DIM; i++) begin
                    if (row[t][i]) begin
                        psum = psum + int'(wmodel[base + n * `SNN_IN_DIM + i]);
                    end
                end
                membrane = membrane + psum;
                if (membrane >= `SNN_LIF_THRESH) begin
                    res[n][t] = 1'b1;
                    membrane  = 0;
                end
            end
        end
        return res;
    endfunction

    task automatic tick();
        @(posedge s_clk);
        #1;
    endtask

    task automatic check_spikes(
        input string               name,
        input snn_pkg::spike_out_t expected,
        input snn_pkg::spike_out_t actual
    );
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        check_spikes("q_spikes", exp_q, q_spikes);
        check_spikes("k_spikes", exp_k, k_spikes);
        check_spikes("v_spikes", exp_v, v_spikes);
    endtask

    // One word per cycle through the load port
    task automatic load_weights(input logic [2:0] sel);
        logic signed [`SNN_W_WIDTH-1:0] w;
        for (int a = 0; a < `SNN_WMEM_DEPTH; a++) begin
            if (sel == W_RAND) begin
                lcg_state = lcg_next(lcg_state);
                w         = lcg_state[23:16];
            end else begin
                w = pattern_weight(sel, a);
            end
            wmodel[a]  = w;
            wload.we   = 1'b1;
            wload.addr = `SNN_ADDR_WIDTH'(a);
            wload.data = w;
            tick();
        end
        wload = '0;
    endtask

    task automatic run_entry(input int e);
        load_weights(tests[e].sel);
        // Last results must survive the reload
        check_outputs();
        exp_q    = predict_spikes(tests[e].row, 0);
        exp_k    = predict_spikes(tests[e].row, UNIT_WORDS);
        exp_v    = predict_spikes(tests[e].row, 2 * UNIT_WORDS);
        spike_in = tests[e].row;
        job_req  = 1'b1;
        tick();
        while (job_ack !== 1'b1) begin
            tick();
        end
        check_outputs();
        if (tests[e].has_exp) begin
            check_spikes("q_spikes", tests[e].exp_q, q_spikes);
        end
        // Held request keeps ack and outputs frozen
        for (int h = 0; h < HOLD_CYCLES; h++) begin
            tick();
            check_bit("job_ack", 1'b1, job_ack);
            check_outputs();
        end
        job_req = 1'b0;
        tick();
        check_bit("job_ack", 1'b0, job_ack);
        repeat (2) begin
            tick();
            check_bit("job_ack", 1'b0, job_ack);
            check_outputs();
        end
    endtask

    task automatic fill_table();
        // Zero row and full rows against fixed weight signs
        tests[0] = '{row: 32'h0000_0000, sel: W_RAMP, has_exp: 1'b1, exp_q: 16'h0000};
        tests[1] = '{row: 32'hFFFF_FFFF, sel: W_POS,  has_exp: 1'b1, exp_q: 16'hFFFF};
        // Neuron 0 hits the threshold exactly and neuron 1 carries a negative membrane
        tests[2] = '{row: 32'h0202_0101, sel: W_EDGE, has_exp: 1'b1, exp_q: 16'h0083};
        tests[3] = '{row: 32'hFFFF_FFFF, sel: W_NEG,  has_exp: 1'b1, exp_q: 16'h0000};
        tests[4] = '{row: 32'hA5C3_3C5A, sel: W_RAMP, has_exp: 1'b0, exp_q: 16'h0000};
        // Same row with new weights
        tests[5] = '{row: 32'h0F0F_F0F0, sel: W_RAND, has_exp: 1'b0, exp_q: 16'h0000};
        tests[6] = '{row: 32'h0F0F_F0F0, sel: W_POS,  has_exp: 1'b0, exp_q: 16'h0000};
        tests[7] = '{row: 32'h1234_ABCD, sel: W_RAND, has_exp: 1'b0, exp_q: 16'h0000};
    endtask

    initial begin
        job_req   = 1'b0;
        spike_in  = '0;
        wload     = '0;
        lcg_state = 32'd3;
        errors    = 0;
        checks    = 0;
        exp_q     = '0;
        exp_k     = '0;
        exp_v     = '0;
        fill_table();
        @(posedge rst_n);
        tick();
        check_bit("job_ack", 1'b0, job_ack);
        check_outputs();
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/snn_pkg.sv
hdl/weight_mem.sv
hdl/burst_rr_arbiter.sv
hdl/linear_lif_unit.sv
hdl/qkv_spike_top.sv
tests/tb_clk_gen.sv
tests/qkv_spike_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/10ps --top-module qkv_spike_tb -f src.f -o qkv_sim \
    && ./obj_dir/qkv_sim | tee /dev/stderr | grep -q -x "Regression passed" \
    || { echo "Simulation did not pass"; exit 1; }
